// File: axi_sram_top.f
+incdir+.
axi_sram_pkg.sv
axi_sram_mem.sv
axi_sram_rd_ctrl.sv
axi_sram_wr_ctrl.sv
axi_sram_top.sv
tb_axi_sram_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the SRAM slave testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi_sram_top \
  -f axi_sram_top.f \
  -o sim_axi_sram \
  && ./obj_dir/sim_axi_sram | tee /dev/stderr | grep -qF "Finished with no errors" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: tb_axi_sram_top.sv
// Testbench for the AXI4 SRAM slave; runs directed and random bursts against a memory model
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_consts.svh"

module tb_axi_sram_top;

  import axi_sram_pkg::*;

  localparam int TIMEOUT_CYCLES = 4000;

  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [7:0]             len;
    burst_e                 burst;
    logic                   err;
  } rd_rec_t;

  logic                   aclk = 1'b0;
  logic                   rst_n;
  logic [`AXI_ID_W-1:0]   awid;
  logic [`AXI_ADDR_W-1:0] awaddr;
  logic [7:0]             awlen;
  burst_e                 awburst;
  logic                   awvalid;
  logic                   awready;
  logic [`AXI_DATA_W-1:0] wdata;
  logic [`AXI_STRB_W-1:0] wstrb;
  logic                   wlast;
  logic                   wvalid;
  logic                   wready;
  logic [`AXI_ID_W-1:0]   bid;
  logic [1:0]             bresp;
  logic                   bvalid;
  logic                   bready;
  logic [`AXI_ID_W-1:0]   arid;
  logic [`AXI_ADDR_W-1:0] araddr;
  logic [7:0]             arlen;
  burst_e                 arburst;
  logic                   arvalid;
  logic                   arready;
  logic [`AXI_ID_W-1:0]   rid;
  logic [`AXI_DATA_W-1:0] rdata;
  logic [1:0]             rresp;
  logic                   rlast;
  logic                   rvalid;
  logic                   rready;

  // Expected memory contents and the reads in flight
  logic [`AXI_DATA_W-1:0] model [`SRAM_DEPTH];
  rd_rec_t                rd_q [$];
  logic                   bp_en;

  always #10 aclk = ~aclk;

  axi_sram_top u_axi_sram_top (
    .i_aclk    (aclk),
    .i_rst_n   (rst_n),
    .i_awid    (awid),
    .i_awaddr  (awaddr),
    .i_awlen   (awlen),
    .i_awburst (awburst),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_wdata   (wdata),
    .i_wstrb   (wstrb),
    .i_wlast   (wlast),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .o_bid     (bid),
    .o_bresp   (bresp),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .i_arid    (arid),
    .i_araddr  (araddr),
    .i_arlen   (arlen),
    .i_arburst (arburst),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .o_rid     (rid),
    .o_rdata   (rdata),
    .o_rresp   (rresp),
    .o_rlast   (rlast),
    .o_rvalid  (rvalid),
    .i_rready  (rready)
  );

  // --------------------
  // Checking helpers

  task automatic check_equal(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  // One cycle of a bounded wait
  task automatic step_wait(inout int cnt, input string what);
    @(negedge aclk);
    cnt++;
    if (cnt > TIMEOUT_CYCLES) begin
      $display("Timed out at %0t waiting for %s", $time, what);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  task automatic check_idle_outputs();
    check_equal("o_bvalid", 1'b0, bvalid);
    check_equal("o_rvalid", 1'b0, rvalid);
    check_equal("o_awready", 1'b1, awready);
    check_equal("o_arready", 1'b1, arready);
  endtask

  function automatic logic burst_is_error(input logic [31:0] addr, input logic [7:0] len,
                                          input burst_e burst);
    logic [32:0] last_idx;
    last_idx = {4'b0, addr[31:3]} + ((burst == BURST_INCR) ? 33'(len) : 33'd0);
    return (burst == BURST_WRAP) || (last_idx >= 33'(`SRAM_DEPTH));
  endfunction

  function automatic int model_index(input logic [31:0] addr, input burst_e burst, input int beat);
    return int'(addr[31:3]) + ((burst == BURST_INCR) ? beat : 0);
  endfunction

  function automatic logic pick_ready();
    if (!bp_en) begin
      return 1'b1;
    end
    return ($urandom % 3) != 0;
  endfunction

  // In range for any length up to 16 beats
  function automatic logic [31:0] rand_addr();
    return {19'd0, 10'($urandom % (`SRAM_DEPTH - 16)), 3'd0};
  endfunction

  // --------------------
  // Bus masters

  task automatic write_burst(input logic [3:0] id, input logic [31:0] addr, input logic [7:0] len,
                             input burst_e burst, input logic full_strb);
    logic        err;
    logic        stalled;
    logic        done;
    logic [3:0]  held_id;
    logic [63:0] data;
    logic [7:0]  strb;
    int          idx;
    int          cnt;
    err = burst_is_error(addr, len, burst);
    awid = id;
    awaddr = addr;
    awlen = len;
    awburst = burst;
    awvalid = 1'b1;
    cnt = 0;
    while (!awready) step_wait(cnt, "AW handshake");
    @(negedge aclk);
    awvalid = 1'b0;
    for (int b = 0; b <= int'(len); b++) begin
      if (bp_en && ($urandom % 4 == 0)) begin
        wvalid = 1'b0;
        @(negedge aclk);
      end
      data = {$urandom, $urandom};
      strb = full_strb ? 8'hff : 8'($urandom);
      wdata = data;
      wstrb = strb;
      wlast = (b == int'(len));
      wvalid = 1'b1;
      cnt = 0;
      while (!wready) step_wait(cnt, "W beat acceptance");
      check_equal("o_bvalid", 1'b0, bvalid);
      // Error bursts leave memory untouched
      if (!err) begin
        idx = model_index(addr, burst, b);
        for (int k = 0; k < `AXI_STRB_W; k++) begin
          if (strb[k]) begin
            model[idx][8*k +: 8] = data[8*k +: 8];
          end
        end
      end
      @(negedge aclk);
    end
    wvalid = 1'b0;
    wlast = 1'b0;
    stalled = 1'b0;
    done = 1'b0;
    held_id = '0;
    cnt = 0;
    while (!done) begin
      if (stalled) begin
        check_equal("o_bvalid", 1'b1, bvalid);
        check_equal("o_bid", held_id, bid);
      end
      bready = pick_ready();
      if (bvalid) begin
        check_equal("o_wready", 1'b0, wready);
        check_equal("o_bid", id, bid);
        check_equal("o_bresp", err ? `RESP_SLVERR : `RESP_OKAY, bresp);
        done = bready;
      end
      stalled = bvalid && !bready;
      held_id = bid;
      step_wait(cnt, "B response");
    end
    bready = 1'b0;
    check_equal("o_bvalid", 1'b0, bvalid);
  endtask

  task automatic read_burst(input logic [3:0] id, input logic [31:0] addr, input logic [7:0] len,
                            input burst_e burst);
    rd_rec_t     rec;
    logic [63:0] exp_data;
    logic [63:0] held_data;
    logic [3:0]  held_id;
    logic        held_last;
    logic        stalled;
    int          beat;
    int          cnt;
    rd_q.push_back('{id: id, addr: addr, len: len, burst: burst,
                     err: burst_is_error(addr, len, burst)});
    arid = id;
    araddr = addr;
    arlen = len;
    arburst = burst;
    arvalid = 1'b1;
    cnt = 0;
    while (!arready) step_wait(cnt, "AR handshake");
    @(negedge aclk);
    arvalid = 1'b0;
    rec = rd_q.pop_front();
    beat = 0;
    stalled = 1'b0;
    held_data = '0;
    held_id = '0;
    held_last = 1'b0;
    cnt = 0;
    while (beat <= int'(rec.len)) begin
      if (stalled) begin
        check_equal("o_rvalid", 1'b1, rvalid);
        check_equal("o_rdata", held_data, rdata);
        check_equal("o_rlast", held_last, rlast);
        check_equal("o_rid", held_id, rid);
      end
      rready = pick_ready();
      if (rvalid) begin
        if (rec.err) begin
          exp_data = '0;
        end else begin
          exp_data = model[model_index(rec.addr, rec.burst, beat)];
        end
        check_equal("o_rid", rec.id, rid);
        check_equal("o_rresp", rec.err ? `RESP_SLVERR : `RESP_OKAY, rresp);
        check_equal("o_rlast", beat == int'(rec.len), rlast);
        check_equal("o_rdata", exp_data, rdata);
        if (rready) begin
          beat++;
        end
      end
      stalled = rvalid && !rready;
      held_data = rdata;
      held_last = rlast;
      held_id = rid;
      step_wait(cnt, "R beats");
    end
    rready = 1'b0;
    // No beat beyond arlen+1
    check_equal("o_rvalid", 1'b0, rvalid);
    check_equal("o_arready", 1'b1, arready);
  endtask

  // --------------------
  // Test sequence

  initial begin
    logic [31:0] addr;
    logic [7:0]  len;
    burst_e      bt;
    void'($urandom(32'hdd83));
    rst_n = 1'b0;
    awid = '0;
    awaddr = '0;
    awlen = '0;
    awburst = BURST_INCR;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wlast = 1'b0;
    wvalid = 1'b0;
    bready = 1'b0;
    arid = '0;
    araddr = '0;
    arlen = '0;
    arburst = BURST_INCR;
    arvalid = 1'b0;
    rready = 1'b0;
    bp_en = 1'b0;
    for (int c = 0; c < 10; c++) begin
      @(negedge aclk);
      check_idle_outputs();
    end
    rst_n = 1'b1;
    @(negedge aclk);
    check_idle_outputs();

    // Whole array filled with full strobes in four 256-beat bursts
    for (int q = 0; q < 4; q++) begin
      write_burst(4'(q), 32'(q * 2048), 8'd255, BURST_INCR, 1'b1);
    end
    // Partial strobes read back after each write
    for (int n = 0; n < 8; n++) begin
      addr = rand_addr();
      len = 8'($urandom % 16);
      write_burst(4'($urandom), addr, len, BURST_INCR, 1'b0);
      read_burst(4'($urandom), addr, len, BURST_INCR);
    end
    read_burst(4'hA, 32'h0, 8'd255, BURST_INCR);
    for (int n = 0; n < 8; n++) begin
      read_burst(4'($urandom), rand_addr(), 8'($urandom % 16), BURST_INCR);
    end
    // FIXED bursts leave the last beat in one word
    for (int n = 0; n < 4; n++) begin
      addr = rand_addr();
      write_burst(4'($urandom), addr, 8'($urandom % 16), BURST_FIXED, 1'b1);
      read_burst(4'($urandom), addr, 8'd3, BURST_FIXED);
      read_burst(4'($urandom), addr, 8'd0, BURST_INCR);
    end
    // WRAP and out-of-range bursts
    write_burst(4'h3, 32'h0000_0100, 8'd3, BURST_WRAP, 1'b1);
    read_burst(4'h4, 32'h0000_0100, 8'd3, BURST_INCR);
    write_burst(4'h5, 32'h0000_1fe0, 8'd7, BURST_INCR, 1'b1);
    read_burst(4'h6, 32'h0000_1fe0, 8'd3, BURST_INCR);
    read_burst(4'h7, 32'h0000_1fe0, 8'd7, BURST_INCR);
    read_burst(4'h8, 32'h0000_0100, 8'd3, BURST_WRAP);
    write_burst(4'h9, 32'h0001_0000, 8'd2, BURST_FIXED, 1'b1);
    read_burst(4'hb, 32'h0001_0000, 8'd2, BURST_FIXED);

    // Random mix under back-pressure
    bp_en = 1'b1;
    for (int n = 0; n < 60; n++) begin
      addr = rand_addr();
      len = 8'($urandom % 16);
      bt = ($urandom % 2 == 0) ? BURST_INCR : BURST_FIXED;
      if ($urandom % 2 == 0) begin
        write_burst(4'($urandom), addr, len, bt, 1'($urandom));
      end else begin
        read_burst(4'($urandom), addr, len, bt);
      end
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: axi_sram_top.sv
// AXI4 SRAM slave top level; connects the write and read controllers to the shared memory
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_consts.svh"

module axi_sram_top (
  input  wire                         i_aclk,
  input  wire                         i_rst_n,

  // AW channel
  input  wire [`AXI_ID_W-1:0]         i_awid,
  input  wire [`AXI_ADDR_W-1:0]       i_awaddr,
  input  wire [7:0]                   i_awlen,
  input  wire axi_sram_pkg::burst_e   i_awburst,
  input  wire                         i_awvalid,
  output logic                        o_awready,

  // W channel
  input  wire [`AXI_DATA_W-1:0]       i_wdata,
  input  wire [`AXI_STRB_W-1:0]       i_wstrb,
  input  wire                         i_wlast,
  input  wire                         i_wvalid,
  output logic                        o_wready,

  // B channel
  output logic [`AXI_ID_W-1:0]        o_bid,
  output logic [1:0]                  o_bresp,
  output logic                        o_bvalid,
  input  wire                         i_bready,

  // AR channel
  input  wire [`AXI_ID_W-1:0]         i_arid,
  input  wire [`AXI_ADDR_W-1:0]       i_araddr,
  input  wire [7:0]                   i_arlen,
  input  wire axi_sram_pkg::burst_e   i_arburst,
  input  wire                         i_arvalid,
  output logic                        o_arready,

  // R channel
  output logic [`AXI_ID_W-1:0]        o_rid,
  output logic [`AXI_DATA_W-1:0]      o_rdata,
  output logic [1:0]                  o_rresp,
  output logic                        o_rlast,
  output logic                        o_rvalid,
  input  wire                         i_rready
);

  // Memory port nets
  logic                    mem_we;
  logic [`SRAM_IDX_W-1:0]  mem_widx;
  logic [`AXI_STRB_W-1:0]  mem_wbe;
  logic [`AXI_DATA_W-1:0]  mem_wdata;
  logic                    mem_re;
  logic [`SRAM_IDX_W-1:0]  mem_ridx;
  logic [`AXI_DATA_W-1:0]  mem_rdata;

  axi_sram_wr_ctrl u_wr_ctrl (
    .i_aclk      (i_aclk),
    .i_rst_n     (i_rst_n),
    .i_awid      (i_awid),
    .i_awaddr    (i_awaddr),
    .i_awlen     (i_awlen),
    .i_awburst   (i_awburst),
    .i_awvalid   (i_awvalid),
    .o_awready   (o_awready),
    .i_wdata     (i_wdata),
    .i_wstrb     (i_wstrb),
    .i_wlast     (i_wlast),
    .i_wvalid    (i_wvalid),
    .o_wready    (o_wready),
    .o_bid       (o_bid),
    .o_bresp     (o_bresp),
    .o_bvalid    (o_bvalid),
    .i_bready    (i_bready),
    .o_mem_we    (mem_we),
    .o_mem_widx  (mem_widx),
    .o_mem_wbe   (mem_wbe),
    .o_mem_wdata (mem_wdata)
  );

  axi_sram_rd_ctrl u_rd_ctrl (
    .i_aclk      (i_aclk),
    .i_rst_n     (i_rst_n),
    .i_arid      (i_arid),
    .i_araddr    (i_araddr),
    .i_arlen     (i_arlen),
    .i_arburst   (i_arburst),
    .i_arvalid   (i_arvalid),
    .o_arready   (o_arready),
    .o_rid       (o_rid),
    .o_rdata     (o_rdata),
    .o_rresp     (o_rresp),
    .o_rlast     (o_rlast),
    .o_rvalid    (o_rvalid),
    .i_rready    (i_rready),
    .o_mem_re    (mem_re),
    .o_mem_ridx  (mem_ridx),
    .i_mem_rdata (mem_rdata)
  );

  axi_sram_mem u_mem (
    .i_aclk  (i_aclk),
    .i_we    (mem_we),
    .i_widx  (mem_widx),
    .i_wbe   (mem_wbe),
    .i_wdata (mem_wdata),
    .i_re    (mem_re),
    .i_ridx  (mem_ridx),
    .o_rdata (mem_rdata)
  );

endmodule

`default_nettype wire

// File: axi_sram_wr_ctrl.sv
// AW/W/B channel controller for the SRAM slave; writes accepted beats and returns the response
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_consts.svh"

module axi_sram_wr_ctrl (
  input  wire                         i_aclk,
  input  wire                         i_rst_n,

  // AW channel
  input  wire [`AXI_ID_W-1:0]         i_awid,
  input  wire [`AXI_ADDR_W-1:0]       i_awaddr,
  input  wire [7:0]                   i_awlen,
  input  wire axi_sram_pkg::burst_e   i_awburst,
  input  wire                         i_awvalid,
  output logic                        o_awready,

  // W channel
  input  wire [`AXI_DATA_W-1:0]       i_wdata,
  input  wire [`AXI_STRB_W-1:0]       i_wstrb,
  input  wire                         i_wlast,
  input  wire                         i_wvalid,
  output logic                        o_wready,

  // B channel
  output logic [`AXI_ID_W-1:0]        o_bid,
  output logic [1:0]                  o_bresp,
  output logic                        o_bvalid,
  input  wire                         i_bready,

  // Memory write port
  output logic                        o_mem_we,
  output logic [`SRAM_IDX_W-1:0]      o_mem_widx,
  output logic [`AXI_STRB_W-1:0]      o_mem_wbe,
  output logic [`AXI_DATA_W-1:0]      o_mem_wdata
);

  import axi_sram_pkg::*;

  localparam int unsigned OFF_W  = $clog2(`AXI_STRB_W);
  localparam int unsigned WORD_W = `AXI_ADDR_W - OFF_W;

  wr_state_e               state_q;
  logic [7:0]              cnt_q;
  logic [`AXI_ID_W-1:0]    id_q;
  logic [`SRAM_IDX_W-1:0]  idx_q;
  burst_e                  burst_q;
  logic                    err_q;

  logic                    aw_fire;
  logic                    w_fire;
  logic                    b_fire;
  logic                    last_beat;
  logic [WORD_W-1:0]       first_word;
  logic [WORD_W:0]         last_word;
  logic                    aw_err;

  assign aw_fire   = i_awvalid && o_awready;
  assign w_fire    = i_wvalid && o_wready;
  assign b_fire    = o_bvalid && i_bready;
  assign last_beat = (cnt_q == 8'd0);

  // WRAP, the reserved code and bursts running past the end are errors
  assign first_word = i_awaddr[`AXI_ADDR_W-1:OFF_W];
  assign last_word  = (i_awburst == BURST_INCR) ? {1'b0, first_word} + i_awlen
                                                : {1'b0, first_word};
  assign aw_err     = ((i_awburst != BURST_FIXED) && (i_awburst != BURST_INCR)) ||
                      (last_word >= `SRAM_DEPTH);

  assign o_awready = (state_q == WR_IDLE);
  assign o_wready  = (state_q == WR_DATA);
  assign o_bvalid  = (state_q == WR_RESP);
  assign o_bid     = id_q;
  assign o_bresp   = err_q ? `RESP_SLVERR : `RESP_OKAY;

  // --------------------
  // Memory write

  // Error burst writes nothing, so no out-of-range beat reaches the array
  assign o_mem_we    = w_fire;
  assign o_mem_widx  = idx_q;
  assign o_mem_wbe   = err_q ? '0 : i_wstrb;
  assign o_mem_wdata = i_wdata;

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= WR_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        WR_IDLE: begin
          if (aw_fire) begin
            state_q <= WR_DATA;
            cnt_q   <= i_awlen;
          end
        end
        WR_DATA: begin
          if (w_fire) begin
            cnt_q <= cnt_q - 8'd1;
            if (last_beat) begin
              state_q <= WR_RESP;
            end
          end
        end
        WR_RESP: begin
          if (b_fire) begin
            state_q <= WR_IDLE;
          end
        end
        default: state_q <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      id_q    <= i_awid;
      idx_q   <= i_awaddr[OFF_W +: `SRAM_IDX_W];
      burst_q <= i_awburst;
      err_q   <= aw_err;
    end else if (w_fire && (burst_q == BURST_INCR)) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  // --------------------
  // Checks

  a_wlast_count: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    w_fire |-> (i_wlast == last_beat))
    else $error("wlast does not match the AW length");

  a_bvalid_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bid) && $stable(o_bresp))
    else $error("B response dropped before bready");

endmodule

`default_nettype wire

// File: axi_sram_rd_ctrl.sv
// AR/R channel controller for the SRAM slave; issues memory reads and drives the R channel
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_consts.svh"

module axi_sram_rd_ctrl (
  input  wire                         i_aclk,
  input  wire                         i_rst_n,

  // AR channel
  input  wire [`AXI_ID_W-1:0]         i_arid,
  input  wire [`AXI_ADDR_W-1:0]       i_araddr,
  input  wire [7:0]                   i_arlen,
  input  wire axi_sram_pkg::burst_e   i_arburst,
  input  wire                         i_arvalid,
  output logic                        o_arready,

  // R channel
  output logic [`AXI_ID_W-1:0]        o_rid,
  output logic [`AXI_DATA_W-1:0]      o_rdata,
  output logic [1:0]                  o_rresp,
  output logic                        o_rlast,
  output logic                        o_rvalid,
  input  wire                         i_rready,

  // Memory read port
  output logic                        o_mem_re,
  output logic [`SRAM_IDX_W-1:0]      o_mem_ridx,
  input  wire [`AXI_DATA_W-1:0]       i_mem_rdata
);

  import axi_sram_pkg::*;

  localparam int unsigned OFF_W  = $clog2(`AXI_STRB_W);
  localparam int unsigned WORD_W = `AXI_ADDR_W - OFF_W;

  rd_state_e               state_q;
  logic                    ar_gap_q;
  logic                    rvalid_q;
  logic [8:0]              iss_cnt_q;
  logic [8:0]              dlv_cnt_q;
  logic [`AXI_ID_W-1:0]    id_q;
  logic [`SRAM_IDX_W-1:0]  idx_q;
  logic [7:0]              len_q;
  burst_e                  burst_q;
  logic                    err_q;

  logic                    ar_fire;
  logic                    r_fire;
  logic                    issue;
  logic [WORD_W-1:0]       first_word;
  logic [WORD_W:0]         last_word;
  logic                    ar_err;

  assign ar_fire = i_arvalid && o_arready;
  assign r_fire  = o_rvalid && i_rready;

  // Burst error decided once at AR from the last beat's word
  assign first_word = i_araddr[`AXI_ADDR_W-1:OFF_W];
  assign last_word  = (i_arburst == BURST_INCR) ? {1'b0, first_word} + i_arlen
                                                : {1'b0, first_word};
  assign ar_err     = ((i_arburst != BURST_FIXED) && (i_arburst != BURST_INCR)) ||
                      (last_word >= `SRAM_DEPTH);

  // --------------------
  // Read issue

  // At most one read in flight until the current beat leaves
  assign issue = (state_q == RD_BURST) && !ar_gap_q &&
                 (iss_cnt_q <= {1'b0, len_q}) && (!o_rvalid || i_rready);

  assign o_mem_re   = issue;
  assign o_mem_ridx = idx_q;

  // --------------------
  // R channel outputs

  assign o_arready = (state_q == RD_IDLE);
  assign o_rvalid  = rvalid_q;
  assign o_rdata   = err_q ? '0 : i_mem_rdata;
  assign o_rlast   = rvalid_q && (dlv_cnt_q == {1'b0, len_q});
  assign o_rid     = id_q;
  assign o_rresp   = err_q ? `RESP_SLVERR : `RESP_OKAY;

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q   <= RD_IDLE;
      ar_gap_q  <= 1'b0;
      rvalid_q  <= 1'b0;
      iss_cnt_q <= '0;
      dlv_cnt_q <= '0;
    end else begin
      // First read waits one cycle after AR
      ar_gap_q <= ar_fire;
      if (issue) begin
        rvalid_q  <= 1'b1;
        iss_cnt_q <= iss_cnt_q + 9'd1;
      end else if (r_fire) begin
        rvalid_q <= 1'b0;
      end
      if (r_fire) begin
        dlv_cnt_q <= dlv_cnt_q + 9'd1;
      end
      case (state_q)
        RD_IDLE: begin
          if (ar_fire) begin
            state_q   <= RD_BURST;
            iss_cnt_q <= '0;
            dlv_cnt_q <= '0;
          end
        end
        RD_BURST: begin
          if (r_fire && o_rlast) begin
            state_q <= RD_IDLE;
          end
        end
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  // Burst fields held from AR
  // INCR steps one word per issued read
  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      id_q    <= i_arid;
      idx_q   <= i_araddr[OFF_W +: `SRAM_IDX_W];
      len_q   <= i_arlen;
      burst_q <= i_arburst;
      err_q   <= ar_err;
    end else if (issue && (burst_q == BURST_INCR)) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  // --------------------
  // Checks

  a_r_stall_stable: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rlast))
    else $error("R payload changed while stalled");

  a_issue_credit: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    iss_cnt_q <= dlv_cnt_q + 9'd1)
    else $error("read issued beyond one beat of credit");

endmodule

`default_nettype wire

// File: axi_sram_mem.sv
// Word-addressed SRAM with a byte-strobed write port and a registered read port
`timescale 1ns/1ps
`default_nettype none

`include "axi_sram_consts.svh"

module axi_sram_mem (
  input  wire                    i_aclk,

  // Write port
  input  wire                    i_we,
  input  wire [`SRAM_IDX_W-1:0]  i_widx,
  input  wire [`AXI_STRB_W-1:0]  i_wbe,
  input  wire [`AXI_DATA_W-1:0]  i_wdata,

  // Read port
  input  wire                    i_re,
  input  wire [`SRAM_IDX_W-1:0]  i_ridx,
  output logic [`AXI_DATA_W-1:0] o_rdata
);

  logic [`AXI_DATA_W-1:0] mem_q [`SRAM_DEPTH];

  // --------------------
  // Write

  // Each strobe bit guards one byte lane
  always_ff @(posedge i_aclk) begin
    if (i_we) begin
      for (int b = 0; b < `AXI_STRB_W; b++) begin
        if (i_wbe[b]) begin
          mem_q[i_widx][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  // --------------------
  // Read

  // Output only moves on an enable and holds the last word otherwise
  // A read and write to the same word in one cycle sees the old data
  always_ff @(posedge i_aclk) begin
    if (i_re) begin
      o_rdata <= mem_q[i_ridx];
    end
  end

endmodule

`default_nettype wire

// File: axi_sram_pkg.sv
// Types shared by the SRAM slave controllers: burst encoding and FSM states
`default_nettype none

package axi_sram_pkg;

  // AXI burst field encoding
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  typedef enum logic {
    RD_IDLE,
    RD_BURST
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

endpackage

`default_nettype wire

// File: axi_sram_consts.svh
// Bus widths, memory size and response codes; include wherever these values are needed
`ifndef AXI_SRAM_CONSTS_SVH
`define AXI_SRAM_CONSTS_SVH

// --------------------
// Bus widths

`define AXI_DATA_W 64
// One strobe bit per data byte
`define AXI_STRB_W 8
`define AXI_ADDR_W 32
`define AXI_ID_W 4

// --------------------
// Memory size

// Depth in 64-bit words
`define SRAM_DEPTH 1024
`define SRAM_IDX_W 10

// --------------------
// Response codes

`define RESP_OKAY 2'b00
`define RESP_SLVERR 2'b10

`endif
